// File: src/ciPkg.sv
`default_nettype none

package ciPkg;

  localparam int wordWidth    = 32;
  localparam int ciIdWidth    = 8;
  localparam int counterWidth = 32;

  // Custom instruction numbers as seen by the processor
  localparam logic [ciIdWidth-1:0] swapByteId  = 8'd1;
  localparam logic [ciIdWidth-1:0] grayscaleId = 8'd9;
  localparam logic [ciIdWidth-1:0] profileId   = 8'd12;

  // Broadcast to every unit, start is a one cycle strobe
  typedef struct packed {
    logic                 start;
    logic [ciIdWidth-1:0] ciN;
    logic [wordWidth-1:0] dataA;
    logic [wordWidth-1:0] dataB;
  } ciRequest;

  // Result must stay zero outside the done cycle
  typedef struct packed {
    logic                 done;
    logic [wordWidth-1:0] result;
  } ciResponse;

endpackage

`default_nettype wire

// File: src/swapByteIse.sv
`default_nettype none

module swapByteIse (
  input  logic             systemClock,
  input  logic             reset,
  input  ciPkg::ciRequest  request,
  output ciPkg::ciResponse response
);

  logic                        select;
  logic [ciPkg::wordWidth-1:0] swapped;

  assign select = request.start && (request.ciN == ciPkg::swapByteId);

  always_comb begin
    if (request.dataB[0]) begin
      // Swap inside each halfword
      swapped = {request.dataA[23:16], request.dataA[31:24],
                 request.dataA[7:0], request.dataA[15:8]};
    end else begin
      swapped = {request.dataA[7:0], request.dataA[15:8],
                 request.dataA[23:16], request.dataA[31:24]};  // Full reversal
    end
  end

  always_ff @(posedge systemClock) begin
    if (reset) begin
      response.done   <= 1'b0;
      response.result <= '0;
    end else begin
      response.done   <= select;
      response.result <= select ? swapped : '0;
    end
  end

  // One cycle latency, never a done on its own
  doneAfterStart : assert property (
    @(posedge systemClock) disable iff (reset)
    response.done |-> $past(request.start && (request.ciN == ciPkg::swapByteId))
  );

endmodule

`default_nettype wire

// File: src/rgb565GrayscaleIse.sv
`default_nettype none

module rgb565GrayscaleIse (
  input  logic             systemClock,
  input  logic             reset,
  input  ciPkg::ciRequest  request,
  output ciPkg::ciResponse response
);

  logic        select;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;

  logic        validStage1;
  logic [15:0] redProduct;
  logic [15:0] greenProduct;
  logic [15:0] blueProduct;
  logic [15:0] graySum;

  assign select = request.start && (request.ciN == ciPkg::grayscaleId);

  // RGB565 in the low halfword, widened to 8 bits per component
  assign red   = {request.dataA[15:11], 3'b000};
  assign green = {request.dataA[10:5], 2'b00};
  assign blue  = {request.dataA[4:0], 3'b000};

  // Stage 1

  always_ff @(posedge systemClock) begin
    if (reset) begin
      validStage1 <= 1'b0;
    end else begin
      validStage1 <= select;
    end
  end

  always_ff @(posedge systemClock) begin
    redProduct   <= red * 8'd54;
    greenProduct <= green * 8'd183;
    blueProduct  <= blue * 8'd19;
  end

  // Weights add up to 256 so the sum cannot exceed 16 bits
  assign graySum = redProduct + greenProduct + blueProduct;

  // Stage 2

  always_ff @(posedge systemClock) begin
    if (reset) begin
      response.done   <= 1'b0;
      response.result <= '0;
    end else begin
      response.done   <= validStage1;
      response.result <= validStage1 ? {{(ciPkg::wordWidth-8){1'b0}}, graySum[15:8]} : '0;
    end
  end

  // Needed by the OR merge in the top level
  resultZeroWhenIdle : assert property (
    @(posedge systemClock) disable iff (reset)
    !response.done |-> (response.result == '0)
  );

endmodule

`default_nettype wire

// File: src/profileCi.sv
`default_nettype none

module profileCi (
  input  logic             systemClock,
  input  logic             reset,
  input  ciPkg::ciRequest  request,
  input  logic             stall,
  input  logic             busIdle,
  output ciPkg::ciResponse response
);

  localparam int numCounters = 3;

  logic                           select;
  logic [numCounters-1:0]         enables;
  logic [numCounters-1:0]         events;
  logic [numCounters-1:0]         clearCounters;
  logic [ciPkg::counterWidth-1:0] counters [numCounters];
  logic [ciPkg::wordWidth-1:0]    readValue;

  assign select = request.start && (request.ciN == ciPkg::profileId);

  // Counter 0 counts every clock cycle
  assign events = {busIdle, stall, 1'b1};

  assign clearCounters = select ? request.dataA[10:8] : '0;

  // Set bits in 2:0 and clear bits in 6:4, clear wins on a conflict
  always_ff @(posedge systemClock) begin
    if (reset) begin
      enables <= '0;
    end else if (select) begin
      enables <= (enables | request.dataA[2:0]) & ~request.dataA[6:4];
    end
  end

  always_ff @(posedge systemClock) begin
    for (int i = 0; i < numCounters; i++) begin
      if (reset || clearCounters[i]) begin
        counters[i] <= '0;
      end else if (enables[i] && events[i]) begin
        counters[i] <= counters[i] + 1'b1;  // Wraps
      end
    end
  end

  // Value as it stands in the start cycle
  always_comb begin
    case (request.dataB[1:0])
      2'd0:    readValue = counters[0];
      2'd1:    readValue = counters[1];
      2'd2:    readValue = counters[2];
      default: readValue = {{(ciPkg::wordWidth-numCounters){1'b0}}, enables};
    endcase
  end

  always_ff @(posedge systemClock) begin
    if (reset) begin
      response.done   <= 1'b0;
      response.result <= '0;
    end else begin
      response.done   <= select;
      response.result <= select ? readValue : '0;
    end
  end

  doneAfterStart : assert property (
    @(posedge systemClock) disable iff (reset)
    response.done |-> $past(request.start && (request.ciN == ciPkg::profileId))
  );

endmodule

`default_nettype wire

// File: src/ciComplex.sv
`default_nettype none

module ciComplex (
  input  logic             systemClock,
  input  logic             reset,
  input  ciPkg::ciRequest  request,
  input  logic             stall,
  input  logic             busIdle,
  output ciPkg::ciResponse response
);

  ciPkg::ciResponse swapResponse;
  ciPkg::ciResponse grayResponse;
  ciPkg::ciResponse profileResponse;

  swapByteIse swapByte0 (
    .systemClock(systemClock),
    .reset(reset),
    .request(request),
    .response(swapResponse)
  );

  rgb565GrayscaleIse grayscale0 (
    .systemClock(systemClock),
    .reset(reset),
    .request(request),
    .response(grayResponse)
  );

  profileCi profiler0 (
    .systemClock(systemClock),
    .reset(reset),
    .request(request),
    .stall(stall),
    .busIdle(busIdle),
    .response(profileResponse)
  );

  // Idle units drive zero so a plain OR merges them
  assign response.done   = swapResponse.done | grayResponse.done | profileResponse.done;
  assign response.result = swapResponse.result | grayResponse.result
                           | profileResponse.result;

endmodule

`default_nettype wire

// File: bench/ciComplexTb.sv
`default_nettype none

module ciComplexTb;

  timeunit 1ns;
  timeprecision 1ns;

  localparam int numSlots      = 29;
  localparam int fieldsPerSlot = 7;  // ciN dataA dataB stall busIdle result doneFlag
  localparam int slotCycles    = 4;
  localparam int resetCycles   = 3;
  localparam int halfPeriod    = 20;
  localparam int timeoutCycles = numSlots * slotCycles + 20;

  logic             systemClock;
  logic             reset;
  logic             stall;
  logic             busIdle;
  ciPkg::ciRequest  request;
  ciPkg::ciResponse response;

  logic [31:0] trace [numSlots*fieldsPerSlot];

  int resultErrors;
  int doneErrors;
  int traceErrors;
  int cycleCount;

  ciComplex dut0 (
    .systemClock(systemClock),
    .reset(reset),
    .request(request),
    .stall(stall),
    .busIdle(busIdle),
    .response(response)
  );

  initial begin
    systemClock = 1'b0;
    forever #halfPeriod systemClock = ~systemClock;
  end

  // Cycles from the start sample to done, per instruction number
  function automatic int latencyOf(input logic [ciPkg::ciIdWidth-1:0] ciN);
    if (ciN == ciPkg::grayscaleId) begin
      return 2;
    end
    return 1;
  endfunction

  // Every field of every slot must have been read from the file
  task automatic checkTrace();
    int base;
    for (int slot = 0; slot < numSlots; slot++) begin
      base = slot * fieldsPerSlot;
      for (int field = 0; field < fieldsPerSlot; field++) begin
        traceFieldKnown : assert (!$isunknown(trace[base+field])) else begin
          traceErrors++;
          $display("Trace slot %0d field %0d is missing or unreadable", slot, field);
        end
      end
      doneFlagValid : assert (trace[base+6] <= 32'd1) else begin
        traceErrors++;
        $display("Trace slot %0d has a done flag other than 0 or 1", slot);
      end
    end
  endtask

  // Offset counts negedges since the one that raised start
  task automatic checkCycle(input int slot, input int offset, input logic doneFlag,
                            input logic [31:0] expected, input int latency);
    logic wantDone;
    wantDone = doneFlag && (offset == latency);
    if (wantDone) begin
      doneArrived : assert (response.done === 1'b1) else begin
        doneErrors++;
        $display("Slot %0d: done did not arrive %0d cycles after start", slot, latency);
      end
      resultMatches : assert (response.result === expected) else begin
        resultErrors++;
        $display("FAILED slot %0d response.result expected %h got %h",
                 slot, expected, response.result);
      end
    end else begin
      noExtraDone : assert (response.done === 1'b0) else begin
        doneErrors++;
        $display("Slot %0d: unexpected done %0d cycles after start", slot, offset);
      end
      resultIdleZero : assert (response.result === '0) else begin
        resultErrors++;
        $display("FAILED slot %0d response.result expected %h got %h",
                 slot, 32'h0, response.result);
      end
    end
  endtask

  task automatic runSlot(input int slot);
    int          base;
    int          latency;
    logic        doneFlag;
    logic [31:0] expected;
    base     = slot * fieldsPerSlot;
    latency  = latencyOf(trace[base][ciPkg::ciIdWidth-1:0]);
    expected = trace[base+5];
    doneFlag = trace[base+6][0];

    @(negedge systemClock);
    // Last cycle of the previous slot, nothing may be pending
    checkCycle(slot, 0, 1'b0, 32'h0, latency);
    request.start = 1'b1;
    request.ciN   = trace[base][ciPkg::ciIdWidth-1:0];
    request.dataA = trace[base+1];
    request.dataB = trace[base+2];
    stall         = trace[base+3][0];  // Held for the whole slot
    busIdle       = trace[base+4][0];

    for (int offset = 1; offset < slotCycles; offset++) begin
      @(negedge systemClock);
      checkCycle(slot, offset, doneFlag, expected, latency);
      request.start = 1'b0;
    end
  endtask

  initial begin
    resultErrors = 0;
    doneErrors   = 0;
    traceErrors  = 0;
    reset        = 1'b1;
    stall        = 1'b0;
    busIdle      = 1'b0;
    request      = '0;

    $readmemh("bench/ciTrace.hex", trace);
    checkTrace();

    repeat (resetCycles) begin
      @(negedge systemClock);
      resetClears : assert (response === '0) else begin
        resultErrors++;
        $display("FAILED response during reset expected %h got %h",
                 {1'b0, 32'h0}, response);
      end
    end
    reset = 1'b0;

    for (int slot = 0; slot < numSlots; slot++) begin
      runSlot(slot);
    end

    // Trailing idle cycle after the last slot
    @(negedge systemClock);
    checkCycle(numSlots, 0, 1'b0, 32'h0, 1);

    $display("Errors: %0d result, %0d done, %0d trace",
             resultErrors, doneErrors, traceErrors);
    if (resultErrors + doneErrors + traceErrors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge systemClock);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
    $display("Errors: %0d result, %0d done, %0d trace",
             resultErrors, doneErrors, traceErrors);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/ciTrace.hex
// One 4-cycle slot per line, start pulsed in the first cycle
// ciN dataA dataB stall busIdle expectedResult doneExpected
// Reset state, then clear and enable all counters
0c 00000000 00000003 1 1 00000000 1
0c 00000000 00000000 0 0 00000000 1
0c 00000707 00000003 1 0 00000000 1
// Byte swap, full reversal and within halfwords
01 11223344 00000000 0 1 44332211 1
01 A1B2C3D4 00000001 1 1 B2A1D4C3 1
// Counter reads
0c 00000000 00000000 0 0 0000000B 1
0c 00000000 00000001 0 0 00000007 1
0c 00000000 00000002 0 0 00000008 1
// Grayscale in back-to-back slots
09 0000FFFF 00000000 0 0 000000FA 1
09 1234F800 00000000 0 0 00000034 1
09 000007E0 00000000 0 0 000000B4 1
09 0000001F 00000000 0 0 00000012 1
09 00008410 00000000 0 0 00000080 1
// Unknown instruction numbers
05 DEADBEEF 00000000 0 0 00000000 0
00 DEADBEEF FFFFFFFF 0 0 00000000 0
// Disable stall counter, then check it is frozen
0c 00000020 00000003 1 0 00000007 1
0c 00000000 00000003 1 1 00000005 1
0c 00000000 00000001 1 0 00000008 1
0c 00000000 00000000 0 0 0000003F 1
0c 00000000 00000002 0 0 0000000C 1
// Clear counter 0 only
0c 00000100 00000000 0 0 00000047 1
0c 00000000 00000000 0 0 00000003 1
01 00FF00FF 00000000 0 0 FF00FF00 1
01 12345678 00000003 0 0 34127856 1
09 00000000 00000000 0 0 00000000 1
0c 00000000 00000004 0 0 00000013 1
// Disable everything
0c 00000070 00000003 0 0 00000005 1
0c 00000000 00000000 0 0 00000018 1
0c 00000000 00000003 0 0 00000000 1

// File: tb.f
src/ciPkg.sv
src/swapByteIse.sv
src/rgb565GrayscaleIse.sv
src/profileCi.sv
src/ciComplex.sv
bench/ciComplexTb.sv

// File: Bender.yml
package:
  name: ci_complex

dependencies: {}

sources:
  # Package first, units before the top level
  - src/ciPkg.sv
  - src/swapByteIse.sv
  - src/rgb565GrayscaleIse.sv
  - src/profileCi.sv
  - src/ciComplex.sv

  # Testbench, top module ciComplexTb
  - target: test
    files:
      - bench/ciComplexTb.sv

# Stimulus is read at run time from bench/ciTrace.hex
# relative to the project root
